// ==== logic/mci_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, types, register map and boot FSM states of the
// management core. Imported by the CSR bank, watchdog and sequencer
// ~~~~~~~~~~~~~~~~~~~~

package mci_pkg;

    // MCU reset held low for 2**width cycles on a request
    localparam int MCU_RST_COUNTER_WIDTH = 4;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] wdt_period_t;
    typedef logic [31:0] err_vec_t;
    typedef logic [31:0] generic_wires_t;
    typedef logic [MCU_RST_COUNTER_WIDTH-1:0] rst_cnt_t;

    // Register byte addresses, low two bits ignored by decode
    localparam reg_addr_t ADDR_BOOT_GO         = 8'h00;
    localparam reg_addr_t ADDR_RESET_REQUEST   = 8'h04;
    localparam reg_addr_t ADDR_RESET_STATUS    = 8'h08;
    localparam reg_addr_t ADDR_WDT1_EN         = 8'h10;
    localparam reg_addr_t ADDR_WDT1_CTRL       = 8'h14;
    localparam reg_addr_t ADDR_WDT1_PERIOD     = 8'h18;
    localparam reg_addr_t ADDR_WDT2_EN         = 8'h1C;
    localparam reg_addr_t ADDR_WDT2_CTRL       = 8'h20;
    localparam reg_addr_t ADDR_WDT2_PERIOD     = 8'h24;
    localparam reg_addr_t ADDR_WDT_STATUS      = 8'h28;
    localparam reg_addr_t ADDR_ERROR_FATAL     = 8'h30;
    localparam reg_addr_t ADDR_ERROR_NON_FATAL = 8'h34;
    localparam reg_addr_t ADDR_GENERIC_IN      = 8'h40;
    localparam reg_addr_t ADDR_GENERIC_OUT     = 8'h44;

    // Boot sequencer states
    typedef enum logic [2:0] {
        BOOT_IDLE,
        BOOT_LC_INIT,
        BOOT_LC_WAIT,
        BOOT_FC_INIT,
        BOOT_FC_WAIT,
        BOOT_MCU_RUN,
        BOOT_MCU_RST
    } boot_state_t;

endpackage

// ==== logic/mci_wdt_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Watchdog control and status between the CSR bank and the timers
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface mci_wdt_if;
    import mci_pkg::*;

    // Configuration from the CSR bank
    logic        timer1_en;
    logic        timer2_en;
    wdt_period_t timer1_period;
    wdt_period_t timer2_period;

    // One-cycle pulses from W1 and W1C writes
    logic timer1_restart;
    logic timer2_restart;
    logic t1_serviced;
    logic t2_serviced;

    // Timeout levels and their set pulses
    logic t1_timeout;
    logic t2_timeout;
    logic t1_timeout_p;
    logic t2_timeout_p;

    modport reg_side (
        output timer1_en, timer2_en, timer1_period, timer2_period,
        output timer1_restart, timer2_restart, t1_serviced, t2_serviced,
        input  t1_timeout, t2_timeout, t1_timeout_p, t2_timeout_p
    );

    modport wdt_side (
        input  timer1_en, timer2_en, timer1_period, timer2_period,
        input  timer1_restart, timer2_restart, t1_serviced, t2_serviced,
        output t1_timeout, t2_timeout, t1_timeout_p, t2_timeout_p
    );

endinterface

// ==== logic/mci_boot_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Boot-go and MCU reset request path between CSR bank and sequencer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface mci_boot_if;

    // Level, released to the sequencer from the CSR bank
    logic boot_go;
    // One-cycle pulse on a W1 write
    logic mcu_rst_req;

    // Pulses at the start of a requested MCU reset
    // First request only
    logic fw_boot_upd_reset;
    // Every later request
    logic fw_hitless_upd_reset;

    modport reg_side (
        output boot_go, mcu_rst_req,
        input  fw_boot_upd_reset, fw_hitless_upd_reset
    );

    modport seqr_side (
        input  boot_go, mcu_rst_req,
        output fw_boot_upd_reset, fw_hitless_upd_reset
    );

endinterface

// ==== logic/mci_reg_block.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// CSR bank on the strobe register bus. Holds configuration, sticky
// error and reset status, and issues write-one pulses to the blocks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_reg_block (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  mci_pkg::reg_addr_t      reg_addr,
    input  mci_pkg::data_t          reg_wdata,
    output mci_pkg::data_t          reg_rdata,
    input  mci_pkg::err_vec_t       agg_error_fatal,
    input  mci_pkg::err_vec_t       agg_error_non_fatal,
    output logic                    mci_error_fatal,
    output logic                    mci_error_non_fatal,
    input  mci_pkg::generic_wires_t mci_generic_input_wires,
    output mci_pkg::generic_wires_t mci_generic_output_wires,
    mci_wdt_if.reg_side             wdt,
    mci_boot_if.reg_side            boot
);
    import mci_pkg::*;

    reg_addr_t      word_addr;
    data_t          rd_mux;
    logic           boot_go_q;
    logic           wdt1_en_q;
    logic           wdt2_en_q;
    wdt_period_t    wdt1_period_q;
    wdt_period_t    wdt2_period_q;
    logic [1:0]     wdt_status_q;
    logic [1:0]     rst_status_q;
    err_vec_t       err_fatal_q;
    err_vec_t       err_non_fatal_q;
    generic_wires_t generic_out_q;

    // Word aligned decode
    assign word_addr = {reg_addr[7:2], 2'b00};

    // Write-one pulses, valid for the edge that takes the write
    assign boot.mcu_rst_req   = reg_wr && (word_addr == ADDR_RESET_REQUEST) && reg_wdata[0];
    assign wdt.timer1_restart = reg_wr && (word_addr == ADDR_WDT1_CTRL) && reg_wdata[0];
    assign wdt.timer2_restart = reg_wr && (word_addr == ADDR_WDT2_CTRL) && reg_wdata[0];
    // Clearing a status bit services that timer
    assign wdt.t1_serviced    = reg_wr && (word_addr == ADDR_WDT_STATUS) && reg_wdata[0];
    assign wdt.t2_serviced    = reg_wr && (word_addr == ADDR_WDT_STATUS) && reg_wdata[1];

    assign boot.boot_go       = boot_go_q;
    assign wdt.timer1_en      = wdt1_en_q;
    assign wdt.timer2_en      = wdt2_en_q;
    assign wdt.timer1_period  = wdt1_period_q;
    assign wdt.timer2_period  = wdt2_period_q;

    assign mci_generic_output_wires = generic_out_q;
    // Any sticky bit raises the aggregate line
    assign mci_error_fatal     = |err_fatal_q;
    assign mci_error_non_fatal = |err_non_fatal_q;

    // Plain read/write configuration
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            boot_go_q     <= 1'b0;
            wdt1_en_q     <= 1'b0;
            wdt2_en_q     <= 1'b0;
            wdt1_period_q <= '0;
            wdt2_period_q <= '0;
            generic_out_q <= '0;
        end else if (reg_wr) begin
            case (word_addr)
                ADDR_BOOT_GO:     boot_go_q     <= reg_wdata[0];
                ADDR_WDT1_EN:     wdt1_en_q     <= reg_wdata[0];
                ADDR_WDT1_PERIOD: wdt1_period_q <= reg_wdata;
                ADDR_WDT2_EN:     wdt2_en_q     <= reg_wdata[0];
                ADDR_WDT2_PERIOD: wdt2_period_q <= reg_wdata;
                ADDR_GENERIC_OUT: generic_out_q <= reg_wdata;
                default: ;
            endcase
        end
    end

    // Sticky bits, W1C; a new event on the clearing edge is kept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_fatal_q     <= '0;
            err_non_fatal_q <= '0;
            rst_status_q    <= '0;
            wdt_status_q    <= '0;
        end else begin
            err_fatal_q <= (err_fatal_q
                & ~((reg_wr && word_addr == ADDR_ERROR_FATAL) ? reg_wdata : '0))
                | agg_error_fatal;
            err_non_fatal_q <= (err_non_fatal_q
                & ~((reg_wr && word_addr == ADDR_ERROR_NON_FATAL) ? reg_wdata : '0))
                | agg_error_non_fatal;
            rst_status_q <= (rst_status_q
                & ~((reg_wr && word_addr == ADDR_RESET_STATUS) ? reg_wdata[1:0] : 2'b00))
                | {boot.fw_hitless_upd_reset, boot.fw_boot_upd_reset};
            // Timeout set pulses already exclude the servicing edge
            wdt_status_q <= (wdt_status_q & ~{wdt.t2_serviced, wdt.t1_serviced})
                | {wdt.t2_timeout_p, wdt.t1_timeout_p};
        end
    end

    // Read mux, unmapped and pulse-only addresses return zero
    always_comb begin
        case (word_addr)
            ADDR_BOOT_GO:         rd_mux = {31'b0, boot_go_q};
            ADDR_RESET_STATUS:    rd_mux = {30'b0, rst_status_q};
            ADDR_WDT1_EN:         rd_mux = {31'b0, wdt1_en_q};
            ADDR_WDT1_PERIOD:     rd_mux = wdt1_period_q;
            ADDR_WDT2_EN:         rd_mux = {31'b0, wdt2_en_q};
            ADDR_WDT2_PERIOD:     rd_mux = wdt2_period_q;
            ADDR_WDT_STATUS:      rd_mux = {30'b0, wdt_status_q};
            ADDR_ERROR_FATAL:     rd_mux = err_fatal_q;
            ADDR_ERROR_NON_FATAL: rd_mux = err_non_fatal_q;
            ADDR_GENERIC_IN:      rd_mux = mci_generic_input_wires;
            ADDR_GENERIC_OUT:     rd_mux = generic_out_q;
            default:              rd_mux = '0;
        endcase
    end

    // Read data one cycle after the strobe, zero in between
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= reg_rd ? rd_mux : '0;
        end
    end

endmodule

// ==== logic/mci_wdt.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Two-stage watchdog. Timer 2 runs behind a timer 1 timeout, so an
// unserviced first stage escalates into the NMI stage
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_wdt (
    input  logic        clk,
    input  logic        arst_n,
    mci_wdt_if.wdt_side wdt
);
    import mci_pkg::*;

    wdt_period_t [1:0] cnt_q;
    wdt_period_t [1:0] period;
    logic [1:0]        run;
    logic [1:0]        restart;
    logic [1:0]        svc;
    logic [1:0]        clr;
    logic [1:0]        hit;
    logic [1:0]        set_p;
    logic [1:0]        timeout_q;

    // Index 0 is timer 1, index 1 is timer 2
    assign period  = {wdt.timer2_period, wdt.timer1_period};
    assign restart = {wdt.timer2_restart, wdt.timer1_restart};
    assign svc     = {wdt.t2_serviced, wdt.t1_serviced};

    // Cascade: first stage timeout starts the second stage
    assign run[0] = wdt.timer1_en;
    assign run[1] = wdt.timer2_en | timeout_q[0];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // Counter back to zero on restart, service or disable
            clr[i]   = restart[i] | svc[i] | ~run[i];
            hit[i]   = run[i] && !timeout_q[i] && (cnt_q[i] == period[i]);
            // Servicing wins over a hit on the same edge
            set_p[i] = hit[i] && !svc[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q     <= '0;
            timeout_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (!timeout_q[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                // Flag held until the status bit is written
                if (svc[i]) begin
                    timeout_q[i] <= 1'b0;
                end else if (set_p[i]) begin
                    timeout_q[i] <= 1'b1;
                end
            end
        end
    end

    assign wdt.t1_timeout   = timeout_q[0];
    assign wdt.t2_timeout   = timeout_q[1];
    assign wdt.t1_timeout_p = set_p[0];
    assign wdt.t2_timeout_p = set_p[1];

endmodule

// ==== logic/mci_boot_seqr.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Boot sequencer. Steps lifecycle and fuse init, releases the MCU and
// Caliptra resets, and runs counted MCU resets for firmware updates
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_boot_seqr (
    input  logic           clk,
    input  logic           arst_n,
    mci_boot_if.seqr_side  boot,
    input  logic           mci_boot_seq_brkpoint,
    output logic           lc_init,
    input  logic           lc_done,
    output logic           fc_opt_init,
    input  logic           fc_opt_done,
    output logic           mcu_rst_b,
    output logic           cptra_rst_b
);
    import mci_pkg::*;

    boot_state_t state_q;
    boot_state_t state_d;
    rst_cnt_t    rst_cnt_q;
    logic        mcu_reset_once_q;
    logic        rst_start;

    // Requests only honoured while the MCU runs
    assign rst_start = (state_q == BOOT_MCU_RUN) && boot.mcu_rst_req;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Breakpoint parks the FSM before any init
            BOOT_IDLE:    if (!mci_boot_seq_brkpoint) state_d = BOOT_LC_INIT;
            BOOT_LC_INIT: state_d = BOOT_LC_WAIT;
            BOOT_LC_WAIT: if (lc_done) state_d = BOOT_FC_INIT;
            BOOT_FC_INIT: state_d = BOOT_FC_WAIT;
            BOOT_FC_WAIT: if (fc_opt_done) state_d = BOOT_MCU_RUN;
            BOOT_MCU_RUN: if (rst_start) state_d = BOOT_MCU_RST;
            // Hold until the counter wraps
            BOOT_MCU_RST: if (&rst_cnt_q) state_d = BOOT_MCU_RUN;
            default:      state_d = BOOT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= BOOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // MCU reset hold counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_cnt_q <= '0;
        end else if (rst_start) begin
            rst_cnt_q <= '0;
        end else if (state_q == BOOT_MCU_RST) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;
        end
    end

    // Registered outputs, decoded from the next state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lc_init     <= 1'b0;
            fc_opt_init <= 1'b0;
            mcu_rst_b   <= 1'b0;
        end else begin
            lc_init     <= (state_d == BOOT_LC_INIT);
            fc_opt_init <= (state_d == BOOT_FC_INIT);
            mcu_rst_b   <= (state_d == BOOT_MCU_RUN);
        end
    end

    // First request is a boot update, later ones hitless
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcu_reset_once_q          <= 1'b0;
            boot.fw_boot_upd_reset    <= 1'b0;
            boot.fw_hitless_upd_reset <= 1'b0;
        end else begin
            mcu_reset_once_q          <= mcu_reset_once_q | rst_start;
            boot.fw_boot_upd_reset    <= rst_start && !mcu_reset_once_q;
            boot.fw_hitless_upd_reset <= rst_start && mcu_reset_once_q;
        end
    end

    // Caliptra out of reset once fuses are done and boot-go is set
    assign cptra_rst_b = boot.boot_go
        && ((state_q == BOOT_MCU_RUN) || (state_q == BOOT_MCU_RST));

endmodule

// ==== logic/mci_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Management core top. Joins the CSR bank, watchdog and boot
// sequencer behind the strobe register bus
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_top (
    input  logic                    clk,
    input  logic                    arst_n,
    // Register bus
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  mci_pkg::reg_addr_t      reg_addr,
    input  mci_pkg::data_t          reg_wdata,
    output mci_pkg::data_t          reg_rdata,
    // Subsystem errors
    input  mci_pkg::err_vec_t       agg_error_fatal,
    input  mci_pkg::err_vec_t       agg_error_non_fatal,
    output logic                    mci_error_fatal,
    output logic                    mci_error_non_fatal,
    // Generic wires
    input  mci_pkg::generic_wires_t mci_generic_input_wires,
    output mci_pkg::generic_wires_t mci_generic_output_wires,
    // Watchdog interrupts
    output logic                    mci_intr,
    output logic                    nmi_intr,
    // Boot and reset control
    input  logic                    mci_boot_seq_brkpoint,
    output logic                    lc_init,
    input  logic                    lc_done,
    output logic                    fc_opt_init,
    input  logic                    fc_opt_done,
    output logic                    mcu_rst_b,
    output logic                    cptra_rst_b
);

    mci_wdt_if  wdt_if ();
    mci_boot_if boot_if ();

    mci_reg_block i_mci_reg_block (
        .clk,
        .arst_n,
        .reg_wr,
        .reg_rd,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .agg_error_fatal,
        .agg_error_non_fatal,
        .mci_error_fatal,
        .mci_error_non_fatal,
        .mci_generic_input_wires,
        .mci_generic_output_wires,
        .wdt  (wdt_if.reg_side),
        .boot (boot_if.reg_side)
    );

    mci_wdt i_mci_wdt (
        .clk,
        .arst_n,
        .wdt (wdt_if.wdt_side)
    );

    mci_boot_seqr i_mci_boot_seqr (
        .clk,
        .arst_n,
        .boot (boot_if.seqr_side),
        .mci_boot_seq_brkpoint,
        .lc_init,
        .lc_done,
        .fc_opt_init,
        .fc_opt_done,
        .mcu_rst_b,
        .cptra_rst_b
    );

    // First stage to the MCU, second stage is the NMI
    assign mci_intr = wdt_if.t1_timeout;
    assign nmi_intr = wdt_if.t2_timeout;

endmodule

// ==== tb/mci_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Protocol and sequencing assertions, bound into the management core top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_checker (
    input logic clk,
    input logic arst_n,
    input logic reg_wr,
    input logic reg_rd,
    input logic lc_init,
    input logic fc_opt_init,
    input logic nmi_intr,
    input logic t1_timeout,
    input logic timer2_en,
    input logic boot_go,
    input logic cptra_rst_b
);

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    // Init strobes are single-cycle pulses
    lc_init_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        lc_init |=> !lc_init)
        else begin
            fail_count++;
            $error("lc_init high for two cycles");
        end

    fc_init_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        fc_opt_init |=> !fc_opt_init)
        else begin
            fail_count++;
            $error("fc_opt_init high for two cycles");
        end

    // Second stage only runs behind timer 1 or its own enable
    nmi_cause: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(nmi_intr) |-> ($past(t1_timeout) || $past(timer2_en)))
        else begin
            fail_count++;
            $error("nmi_intr rose without t1_timeout or timer2_en");
        end

    // Strobes are exclusive on the register bus
    bus_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_wr && reg_rd))
        else begin
            fail_count++;
            $error("reg_wr and reg_rd high together");
        end

    cptra_needs_go: assert property (@(posedge clk) disable iff (!arst_n)
        !boot_go |-> !cptra_rst_b)
        else begin
            fail_count++;
            $error("cptra_rst_b high while boot_go clear");
        end

endmodule

// ==== tb/mci_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the management core. Boot flow, registers,
// error aggregation, watchdog cascade and MCU reset requests
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mci_tb;
    import mci_pkg::*;

    // Signals polled by the bounded wait task
    typedef enum {
        P_LC_INIT,
        P_FC_INIT,
        P_MCU_RST_B,
        P_CPTRA_RST_B,
        P_MCI_INTR,
        P_NMI_INTR
    } probe_t;

    logic           clk;
    logic           arst_n;
    logic           reg_wr;
    logic           reg_rd;
    reg_addr_t      reg_addr;
    data_t          reg_wdata;
    data_t          reg_rdata;
    err_vec_t       agg_error_fatal;
    err_vec_t       agg_error_non_fatal;
    logic           mci_error_fatal;
    logic           mci_error_non_fatal;
    generic_wires_t mci_generic_input_wires;
    generic_wires_t mci_generic_output_wires;
    logic           mci_intr;
    logic           nmi_intr;
    logic           mci_boot_seq_brkpoint;
    logic           lc_init;
    logic           lc_done;
    logic           fc_opt_init;
    logic           fc_opt_done;
    logic           mcu_rst_b;
    logic           cptra_rst_b;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    mci_top i_mci_top (.*);

    bind mci_top mci_checker i_mci_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .lc_init     (lc_init),
        .fc_opt_init (fc_opt_init),
        .nmi_intr    (nmi_intr),
        .t1_timeout  (wdt_if.t1_timeout),
        .timer2_en   (wdt_if.timer2_en),
        .boot_go     (boot_if.boot_go),
        .cptra_rst_b (cptra_rst_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic probe(input probe_t sel);
        case (sel)
            P_LC_INIT:     return lc_init;
            P_FC_INIT:     return fc_opt_init;
            P_MCU_RST_B:   return mcu_rst_b;
            P_CPTRA_RST_B: return cptra_rst_b;
            P_MCI_INTR:    return mci_intr;
            P_NMI_INTR:    return nmi_intr;
            default:       return 1'bx;
        endcase
    endfunction

    task automatic check_data(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Sampled on falling edges away from DUT updates
    task automatic wait_for(input string what, input probe_t sel, input logic level,
                            input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (probe(sel) !== level && n < limit);
        if (probe(sel) !== level) begin
            errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    // Write lands on the second edge
    task automatic reg_write(input reg_addr_t addr, input data_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // Data must be zero during the strobe cycle and valid one cycle later
    task automatic reg_read(input reg_addr_t addr, output data_t data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(negedge clk);
        check_data("reg_rdata during strobe cycle", reg_rdata, '0);
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic read_expect(input reg_addr_t addr, input data_t exp, input string what);
        data_t got;
        reg_read(addr, got);
        check_data(what, got, exp);
    endtask

    task automatic boot_flow_test();
        @(negedge clk);
        check_bit("lc_init after reset", lc_init, 1'b0);
        check_bit("fc_opt_init after reset", fc_opt_init, 1'b0);
        check_bit("mcu_rst_b after reset", mcu_rst_b, 1'b0);
        check_bit("cptra_rst_b after reset", cptra_rst_b, 1'b0);
        check_bit("mci_intr after reset", mci_intr, 1'b0);
        check_bit("nmi_intr after reset", nmi_intr, 1'b0);
        check_bit("mci_error_fatal after reset", mci_error_fatal, 1'b0);
        check_bit("mci_error_non_fatal after reset", mci_error_non_fatal, 1'b0);
        // Parked by the breakpoint
        repeat (6) begin
            @(negedge clk);
            check_bit("lc_init under breakpoint", lc_init, 1'b0);
        end
        @(posedge clk);
        mci_boot_seq_brkpoint <= 1'b0;
        wait_for("lc_init pulse", P_LC_INIT, 1'b1, 10);
        @(negedge clk);
        check_bit("lc_init pulse width", lc_init, 1'b0);
        check_bit("fc_opt_init before lc_done", fc_opt_init, 1'b0);
        @(posedge clk);
        lc_done <= 1'b1;
        wait_for("fc_opt_init pulse", P_FC_INIT, 1'b1, 10);
        @(negedge clk);
        check_bit("fc_opt_init pulse width", fc_opt_init, 1'b0);
        check_bit("mcu_rst_b before fc_opt_done", mcu_rst_b, 1'b0);
        @(posedge clk);
        fc_opt_done <= 1'b1;
        wait_for("mcu_rst_b release", P_MCU_RST_B, 1'b1, 10);
        check_bit("cptra_rst_b before boot-go", cptra_rst_b, 1'b0);
        reg_write(ADDR_BOOT_GO, 32'h1);
        wait_for("cptra_rst_b release", P_CPTRA_RST_B, 1'b1, 5);
        read_expect(ADDR_BOOT_GO, 32'h1, "boot-go readback");
    endtask

    task automatic register_test();
        generic_wires_t out_val;
        generic_wires_t in_val;
        out_val = rand_bits(32);
        in_val  = rand_bits(32);
        reg_write(ADDR_GENERIC_OUT, out_val);
        @(negedge clk);
        check_data("generic output wires", mci_generic_output_wires, out_val);
        read_expect(ADDR_GENERIC_OUT, out_val, "generic output readback");
        // Data back to zero once the strobe is gone
        @(negedge clk);
        check_data("reg_rdata after read cycle", reg_rdata, '0);
        @(posedge clk);
        mci_generic_input_wires <= in_val;
        read_expect(ADDR_GENERIC_IN, in_val, "generic input readback");
        // Byte offset within a word is ignored
        read_expect(8'h47, out_val, "generic output at unaligned address");
        // Unmapped writes are dropped and unmapped reads return zero
        reg_write(8'h0C, 32'hffff_ffff);
        reg_write(8'h48, 32'hffff_ffff);
        read_expect(8'h0C, '0, "unmapped 0x0C");
        read_expect(8'h2C, '0, "unmapped 0x2C");
        read_expect(8'h48, '0, "unmapped 0x48");
        read_expect(8'hFC, '0, "unmapped 0xFC");
        read_expect(ADDR_RESET_REQUEST, '0, "reset request pulse field");
        read_expect(ADDR_GENERIC_OUT, out_val, "generic output after unmapped writes");
    endtask

    task automatic error_test();
        err_vec_t exp_fatal;
        err_vec_t exp_non_fatal;
        err_vec_t pat_fatal;
        err_vec_t pat_non_fatal;
        err_vec_t clr;
        exp_fatal     = '0;
        exp_non_fatal = '0;
        for (int i = 0; i < 4; i++) begin
            // Sparse patterns so the OR stays short of all ones
            pat_fatal     = rand_bits(32) & rand_bits(32);
            pat_non_fatal = rand_bits(32) & rand_bits(32);
            @(posedge clk);
            agg_error_fatal     <= pat_fatal;
            agg_error_non_fatal <= pat_non_fatal;
            @(posedge clk);
            agg_error_fatal     <= '0;
            agg_error_non_fatal <= '0;
            exp_fatal     = exp_fatal | pat_fatal;
            exp_non_fatal = exp_non_fatal | pat_non_fatal;
            @(negedge clk);
            check_bit("mci_error_fatal", mci_error_fatal, |exp_fatal);
            check_bit("mci_error_non_fatal", mci_error_non_fatal, |exp_non_fatal);
        end
        read_expect(ADDR_ERROR_FATAL, exp_fatal, "sticky fatal errors");
        read_expect(ADDR_ERROR_NON_FATAL, exp_non_fatal, "sticky non-fatal errors");
        // W1C of random bits
        clr = rand_bits(32);
        reg_write(ADDR_ERROR_FATAL, clr);
        exp_fatal = exp_fatal & ~clr;
        clr = rand_bits(32);
        reg_write(ADDR_ERROR_NON_FATAL, clr);
        exp_non_fatal = exp_non_fatal & ~clr;
        read_expect(ADDR_ERROR_FATAL, exp_fatal, "fatal errors after W1C");
        read_expect(ADDR_ERROR_NON_FATAL, exp_non_fatal, "non-fatal errors after W1C");
        reg_write(ADDR_ERROR_FATAL, 32'hffff_ffff);
        reg_write(ADDR_ERROR_NON_FATAL, 32'hffff_ffff);
        @(negedge clk);
        check_bit("mci_error_fatal after full clear", mci_error_fatal, 1'b0);
        check_bit("mci_error_non_fatal after full clear", mci_error_non_fatal, 1'b0);
    endtask

    task automatic watchdog_test();
        data_t status;
        reg_write(ADDR_WDT1_PERIOD, 32'd20);
        reg_write(ADDR_WDT2_PERIOD, 32'd20);
        reg_write(ADDR_WDT1_EN, 32'h1);
        wait_for("mci_intr from timer 1", P_MCI_INTR, 1'b1, 100);
        reg_read(ADDR_WDT_STATUS, status);
        check_bit("wdt status t1 timeout", status[0], 1'b1);
        // Cascade alone starts timer 2 while timer2_en is clear
        wait_for("nmi_intr through cascade", P_NMI_INTR, 1'b1, 100);
        read_expect(ADDR_WDT_STATUS, 32'h3, "wdt status both timeouts");
        reg_write(ADDR_WDT_STATUS, 32'h3);
        @(negedge clk);
        check_bit("mci_intr after service", mci_intr, 1'b0);
        check_bit("nmi_intr after service", nmi_intr, 1'b0);
        // Restarts well inside the period
        repeat (8) begin
            reg_write(ADDR_WDT1_CTRL, 32'h1);
            repeat (5) begin
                @(negedge clk);
                check_bit("mci_intr with regular restarts", mci_intr, 1'b0);
            end
        end
        reg_write(ADDR_WDT1_EN, 32'h0);
        read_expect(ADDR_WDT_STATUS, '0, "wdt status after restarts");
    endtask

    task automatic mcu_reset_test();
        int low_cycles;
        for (int req = 0; req < 2; req++) begin
            reg_write(ADDR_RESET_REQUEST, 32'h1);
            wait_for("mcu_rst_b assert", P_MCU_RST_B, 1'b0, 5);
            check_bit("cptra_rst_b during MCU reset", cptra_rst_b, 1'b1);
            low_cycles = 0;
            while (mcu_rst_b === 1'b0 && low_cycles < 40) begin
                low_cycles++;
                @(negedge clk);
            end
            if (mcu_rst_b !== 1'b1) begin
                errors++;
                $display("mcu_rst_b did not return high after a reset request");
            end
            // Hold time is 2**MCU_RST_COUNTER_WIDTH cycles
            check_data("mcu_rst_b low cycles", data_t'(low_cycles), data_t'(16));
            read_expect(ADDR_RESET_STATUS, (req == 0) ? 32'h1 : 32'h3, "reset status");
        end
        reg_write(ADDR_RESET_STATUS, 32'h3);
        read_expect(ADDR_RESET_STATUS, '0, "reset status after W1C");
    endtask

    initial begin
        errors                  = 0;
        checks                  = 0;
        lfsr_state              = 32'h2dc8_f46c;
        arst_n                  = 1'b0;
        reg_wr                  = 1'b0;
        reg_rd                  = 1'b0;
        reg_addr                = '0;
        reg_wdata               = '0;
        agg_error_fatal         = '0;
        agg_error_non_fatal     = '0;
        mci_generic_input_wires = '0;
        mci_boot_seq_brkpoint   = 1'b1;
        lc_done                 = 1'b0;
        fc_opt_done             = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        boot_flow_test();
        register_test();
        error_test();
        watchdog_test();
        mcu_reset_test();
        repeat (2) @(posedge clk);
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, i_mci_top.i_mci_checker.fail_count);
        if (errors == 0 && i_mci_top.i_mci_checker.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mci.f ====
logic/mci_pkg.sv
logic/mci_wdt_if.sv
logic/mci_boot_if.sv
logic/mci_reg_block.sv
logic/mci_wdt.sv
logic/mci_boot_seqr.sv
logic/mci_top.sv
tb/mci_checker.sv
tb/mci_tb.sv

// ==== Makefile ====
# Verilator build and run for the management core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"

test:
	verilator --binary --timing --assert --top-module mci_tb -Mdir obj_dir -f mci.f
	./obj_dir/Vmci_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log || (echo "No result line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
